// ==== hw/gf64_ep_pkg.sv ====
// ---------------------------------------------------------------------
// Shared constants for the GF64 external-product MAC
// Field is 2^64 - 2^32 + 1, every value kept canonical
// GLWE_K_P1 must be a power of two (key row addressing relies on it)
// ---------------------------------------------------------------------
`default_nettype none

package gf64_ep_pkg;

  // Field
  localparam int COEF_W = 64;
  localparam logic [COEF_W-1:0] GF64_P = 64'hFFFF_FFFF_0000_0001;

  // Line geometry
  localparam int GLWE_K_P1 = 2;
  localparam int PBS_L     = 2;
  localparam int ELT_NB    = GLWE_K_P1 * PBS_L;
  localparam int ELT_W     = 2;
  localparam int COL_W     = 1;

  // Multiplier pipeline depth
  localparam int MULT_LAT = 2;

  // ---------------------------------------------------------------------
  // APB register map
  // ---------------------------------------------------------------------
  localparam int APB_AW = 8;
  localparam int APB_DW = 32;

  // Key words, low half first, 2 words per key
  localparam logic [APB_AW-1:0] KEY_BASE = 8'h00;
  localparam int KEY_WORDS = 2 * ELT_NB * GLWE_K_P1;
  localparam int KEY_IDX_W = 4;

  // Bit 0 sticky length error (W1C), bit 1 busy
  localparam logic [APB_AW-1:0] STATUS_ADDR = 8'h40;

  // Sequencer FSM
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_LINE,
    SEQ_DRAIN
  } seq_state_e;

  // Decoded APB access
  typedef enum logic [1:0] {
    APB_OP_NONE,
    APB_OP_RD,
    APB_OP_WR
  } apb_op_e;

endpackage

`default_nettype wire

// ==== hw/gf64_key_regs.sv ====
// ---------------------------------------------------------------------
// APB slave holding the key matrix and the status register
// No wait states, pslverr on any unmapped address
// Keys may only change while the stream is idle
// Key row read is combinational
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module gf64_key_regs (
  input  logic                              clk,
  input  logic                              s_rst_n,
  // APB
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [gf64_ep_pkg::APB_AW-1:0]    paddr_i,
  input  logic [gf64_ep_pkg::APB_DW-1:0]    pwdata_i,
  output logic [gf64_ep_pkg::APB_DW-1:0]    prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o,
  // Datapath row read
  input  logic [gf64_ep_pkg::ELT_W-1:0]     row_i,
  output logic [gf64_ep_pkg::GLWE_K_P1-1:0][gf64_ep_pkg::COEF_W-1:0] key_row_o,
  // Status
  input  logic                              len_err_i,
  input  logic                              busy_i,
  output logic                              error_o
);
  import gf64_ep_pkg::*;

  logic [APB_DW-1:0]    key_mem [KEY_WORDS];
  apb_op_e              apb_op;
  logic [APB_AW-1:0]    key_off;
  logic                 key_hit;
  logic                 status_hit;
  logic [KEY_IDX_W-1:0] row_base;
  logic                 err_q;

  // ---------------------------------------------------------------------
  // Access decode
  // ---------------------------------------------------------------------
  // Only the access phase counts
  always_comb begin
    if (psel_i && penable_i) begin
      apb_op = pwrite_i ? APB_OP_WR : APB_OP_RD;
    end else begin
      apb_op = APB_OP_NONE;
    end
  end

  // Below KEY_BASE wraps to a large offset, so it misses too
  assign key_off    = paddr_i - KEY_BASE;
  assign key_hit    = key_off < APB_AW'(KEY_WORDS * 4);
  assign status_hit = paddr_i == STATUS_ADDR;

  assign pready_o  = 1'b1;
  assign pslverr_o = (apb_op != APB_OP_NONE) && !(key_hit || status_hit);

  // Read mux
  always_comb begin
    if (status_hit) begin
      prdata_o = {{(APB_DW - 2){1'b0}}, busy_i, err_q};
    end else if (key_hit) begin
      prdata_o = key_mem[key_off[KEY_IDX_W+1:2]];
    end else begin
      prdata_o = '0;
    end
  end

  // Key storage
  always_ff @(posedge clk) begin
    if (apb_op == APB_OP_WR && key_hit) begin
      key_mem[key_off[KEY_IDX_W+1:2]] <= pwdata_i;
    end
  end

  // Sticky error, a new error wins over the clear
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      err_q <= 1'b0;
    end else if (len_err_i) begin
      err_q <= 1'b1;
    end else if (apb_op == APB_OP_WR && status_hit && pwdata_i[0]) begin
      err_q <= 1'b0;
    end
  end

  assign error_o = err_q;

  // ---------------------------------------------------------------------
  // Row read, 2*GLWE_K_P1 words per row
  // ---------------------------------------------------------------------
  assign row_base = {row_i, {(COL_W + 1){1'b0}}};

  always_comb begin
    for (int c = 0; c < GLWE_K_P1; c++) begin
      key_row_o[c] = {key_mem[row_base + KEY_IDX_W'(2 * c + 1)],
                      key_mem[row_base + KEY_IDX_W'(2 * c)]};
    end
  end

endmodule

`default_nettype wire

// ==== hw/gf64_mod_mult.sv ====
// ---------------------------------------------------------------------
// Two-stage GF64 modular multiplier
// Inputs must be canonical (below GF64_P), output is canonical
// Side bits follow the data, only avail is reset
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module gf64_mod_mult (
  input  logic                            clk,
  input  logic                            s_rst_n,
  input  logic [gf64_ep_pkg::COEF_W-1:0]  a_i,
  input  logic [gf64_ep_pkg::COEF_W-1:0]  m_i,
  input  logic                            avail_i,
  input  logic                            sol_i,
  input  logic                            eol_i,
  output logic [gf64_ep_pkg::COEF_W-1:0]  z_o,
  output logic                            avail_o,
  output logic                            sol_o,
  output logic                            eol_o
);
  import gf64_ep_pkg::*;

  localparam int PROD_W = 2 * COEF_W;

  logic [PROD_W-1:0]   prod_q;
  logic [PROD_W-1:0]   f1;
  logic [PROD_W-1:0]   f2;
  logic [PROD_W-1:0]   f3;
  logic [PROD_W-1:0]   f4;
  logic [COEF_W-1:0]   red;
  logic [COEF_W-1:0]   red_sub;
  logic [MULT_LAT-1:0] avail_q;
  logic [MULT_LAT-1:0] sol_q;
  logic [MULT_LAT-1:0] eol_q;

  // One fold: hi * 2^64 + lo == hi * (2^32 - 1) + lo
  function automatic logic [PROD_W-1:0] fold(input logic [PROD_W-1:0] x);
    logic [PROD_W-1:0] lo;
    logic [PROD_W-1:0] hi;
    lo = {{COEF_W{1'b0}}, x[COEF_W-1:0]};
    hi = {{COEF_W{1'b0}}, x[PROD_W-1:COEF_W]};
    return lo + (hi << 32) - hi;
  endfunction

  // ---------------------------------------------------------------------
  // Stage 1 full product
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    prod_q <= {{COEF_W{1'b0}}, a_i} * {{COEF_W{1'b0}}, m_i};
  end

  // ---------------------------------------------------------------------
  // Stage 2 reduction
  // ---------------------------------------------------------------------
  // Bounds after each fold: 2^97, 2^66, 2^64 + 3*2^32, then below 2^64
  always_comb begin
    f1      = fold(prod_q);
    f2      = fold(f1);
    f3      = fold(f2);
    f4      = fold(f3);
    red     = f4[COEF_W-1:0];
    // Below 2P here, so one subtract makes it canonical
    red_sub = (red >= GF64_P) ? red - GF64_P : red;
  end

  always_ff @(posedge clk) begin
    z_o <= red_sub;
  end

  // Side pipeline, same depth as the data
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      avail_q <= '0;
    end else begin
      avail_q <= {avail_q[MULT_LAT-2:0], avail_i};
    end
  end

  always_ff @(posedge clk) begin
    sol_q <= {sol_q[MULT_LAT-2:0], sol_i};
    eol_q <= {eol_q[MULT_LAT-2:0], eol_i};
  end

  assign avail_o = avail_q[MULT_LAT-1];
  assign sol_o   = sol_q[MULT_LAT-1];
  assign eol_o   = eol_q[MULT_LAT-1];

endmodule

`default_nettype wire

// ==== hw/gf64_mod_acc.sv ====
// ---------------------------------------------------------------------
// Column accumulator modulo GF64_P
// Inputs must be canonical
// sum_o holds the last line's sum until the next eol
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module gf64_mod_acc (
  input  logic                            clk,
  input  logic                            s_rst_n,
  input  logic [gf64_ep_pkg::COEF_W-1:0]  a_i,
  input  logic                            avail_i,
  input  logic                            sol_i,
  input  logic                            eol_i,
  output logic [gf64_ep_pkg::COEF_W-1:0]  sum_o,
  output logic                            sum_vld_o
);
  import gf64_ep_pkg::*;

  logic [COEF_W-1:0] acc_q;
  logic [COEF_W-1:0] acc_d;
  logic [COEF_W:0]   add;

  // Next running sum
  always_comb begin
    add = {1'b0, acc_q} + {1'b0, a_i};
    if (sol_i) begin
      // First product of the line replaces the old sum
      acc_d = a_i;
    end else if (add >= {1'b0, GF64_P}) begin
      acc_d = COEF_W'(add - {1'b0, GF64_P});
    end else begin
      acc_d = add[COEF_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (avail_i) begin
      acc_q <= acc_d;
    end
    // Hold register for the sequencer
    if (avail_i && eol_i) begin
      sum_o <= acc_d;
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      sum_vld_o <= 1'b0;
    end else begin
      sum_vld_o <= avail_i && eol_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/ep_coef_counter.sv ====
// ---------------------------------------------------------------------
// Coefficient index inside a line
// coef_idx_o is valid in the same cycle as the coefficient
// len_err_o pulses one cycle after the faulty sol or eol
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module ep_coef_counter (
  input  logic                           clk,
  input  logic                           s_rst_n,
  input  logic                           avail_i,
  input  logic                           sol_i,
  input  logic                           eol_i,
  output logic [gf64_ep_pkg::ELT_W-1:0]  coef_idx_o,
  output logic                           len_err_o
);
  import gf64_ep_pkg::*;

  logic [ELT_W-1:0] cnt_q;
  logic             open_q;
  logic             bad_eol;
  logic             bad_sol;

  // sol forces index 0 for the current coefficient
  assign coef_idx_o = sol_i ? '0 : cnt_q;

  assign bad_eol = eol_i && (coef_idx_o != ELT_W'(ELT_NB - 1));
  assign bad_sol = sol_i && open_q;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      cnt_q     <= '0;
      open_q    <= 1'b0;
      len_err_o <= 1'b0;
    end else begin
      len_err_o <= avail_i && (bad_eol || bad_sol);
      if (avail_i) begin
        cnt_q  <= coef_idx_o + 1'b1;
        open_q <= !eol_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/ep_seq_fsm.sv ====
// ---------------------------------------------------------------------
// Output sequencer
// Sends the held column sums one per cycle, column 0 first
// Assumes a line is longer than the drain, so no sum_vld while draining
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module ep_seq_fsm (
  input  logic                           clk,
  input  logic                           s_rst_n,
  input  logic                           in_avail_i,
  input  logic                           in_eol_i,
  input  logic                           sum_vld_i,
  input  logic [gf64_ep_pkg::GLWE_K_P1-1:0][gf64_ep_pkg::COEF_W-1:0] sums_i,
  output logic                           busy_o,
  output logic [gf64_ep_pkg::COEF_W-1:0] out_data_o,
  output logic                           out_avail_o,
  output logic                           out_sol_o,
  output logic                           out_eol_o
);
  import gf64_ep_pkg::*;

  seq_state_e        state_q;
  seq_state_e        state_d;
  logic [COL_W-1:0]  col_q;
  logic              open_q;
  logic [MULT_LAT:0] tail_q;
  logic              pending;
  logic              send;
  logic              last_col;

  // ---------------------------------------------------------------------
  // Line tracking
  // ---------------------------------------------------------------------
  // Open line, or an eol still travelling through mult and acc
  assign pending = open_q || in_avail_i || (|tail_q);

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      open_q <= 1'b0;
      tail_q <= '0;
    end else begin
      tail_q <= {tail_q[MULT_LAT-1:0], in_avail_i && in_eol_i};
      if (in_avail_i) begin
        open_q <= !in_eol_i;
      end
    end
  end

  // ---------------------------------------------------------------------
  // FSM
  // ---------------------------------------------------------------------
  assign last_col = col_q == COL_W'(GLWE_K_P1 - 1);
  // Column 0 goes out on the sum_vld cycle itself
  assign send     = (state_q == SEQ_LINE && sum_vld_i) || state_q == SEQ_DRAIN;

  always_comb begin
    state_d = state_q;
    case (state_q)
      SEQ_IDLE:  if (in_avail_i) state_d = SEQ_LINE;
      SEQ_LINE:  if (sum_vld_i) state_d = SEQ_DRAIN;
      SEQ_DRAIN: if (last_col) state_d = pending ? SEQ_LINE : SEQ_IDLE;
      default:   state_d = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      state_q     <= SEQ_IDLE;
      col_q       <= '0;
      out_avail_o <= 1'b0;
      out_sol_o   <= 1'b0;
      out_eol_o   <= 1'b0;
    end else begin
      state_q     <= state_d;
      out_avail_o <= send;
      out_sol_o   <= send && (col_q == '0);
      out_eol_o   <= send && last_col;
      if (send) begin
        col_q <= last_col ? '0 : col_q + 1'b1;
      end
    end
  end

  // Output data
  always_ff @(posedge clk) begin
    if (send) begin
      out_data_o <= sums_i[col_q];
    end
  end

  assign busy_o = state_q != SEQ_IDLE;

endmodule

`default_nettype wire

// ==== hw/gf64_ext_prod_top.sv ====
// ---------------------------------------------------------------------
// GF64 external-product MAC top level
// Stream has no ready, input must be canonical
// Lines must hold exactly ELT_NB coefficients
// Column 0 leaves 4 cycles after eol, column c at 4 + c
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module gf64_ext_prod_top (
  input  logic                           clk,
  input  logic                           s_rst_n,
  // APB
  input  logic                           psel_i,
  input  logic                           penable_i,
  input  logic                           pwrite_i,
  input  logic [gf64_ep_pkg::APB_AW-1:0] paddr_i,
  input  logic [gf64_ep_pkg::APB_DW-1:0] pwdata_i,
  output logic [gf64_ep_pkg::APB_DW-1:0] prdata_o,
  output logic                           pready_o,
  output logic                           pslverr_o,
  // Input stream
  input  logic [gf64_ep_pkg::COEF_W-1:0] in_data_i,
  input  logic                           in_avail_i,
  input  logic                           in_sol_i,
  input  logic                           in_eol_i,
  // Output stream
  output logic [gf64_ep_pkg::COEF_W-1:0] out_data_o,
  output logic                           out_avail_o,
  output logic                           out_sol_o,
  output logic                           out_eol_o,
  output logic                           error_o
);
  import gf64_ep_pkg::*;

  logic [ELT_W-1:0]                    coef_idx;
  logic                                len_err;
  logic                                busy;
  logic [GLWE_K_P1-1:0][COEF_W-1:0]    key_row;
  logic [GLWE_K_P1-1:0][COEF_W-1:0]    prod;
  logic [GLWE_K_P1-1:0]                prod_avail;
  logic [GLWE_K_P1-1:0]                prod_sol;
  logic [GLWE_K_P1-1:0]                prod_eol;
  logic [GLWE_K_P1-1:0][COEF_W-1:0]    sums;
  logic [GLWE_K_P1-1:0]                sum_vld;

  // Key bank and status
  gf64_key_regs i_key_regs (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .row_i     (coef_idx),
    .key_row_o (key_row),
    .len_err_i (len_err),
    .busy_i    (busy),
    .error_o   (error_o)
  );

  // Row index of the incoming coefficient
  ep_coef_counter i_coef_counter (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .avail_i    (in_avail_i),
    .sol_i      (in_sol_i),
    .eol_i      (in_eol_i),
    .coef_idx_o (coef_idx),
    .len_err_o  (len_err)
  );

  // ---------------------------------------------------------------------
  // One multiply-accumulate lane per key column
  // ---------------------------------------------------------------------
  for (genvar g = 0; g < GLWE_K_P1; g++) begin : gen_lane
    gf64_mod_mult i_mult (
      .clk     (clk),
      .s_rst_n (s_rst_n),
      .a_i     (in_data_i),
      .m_i     (key_row[g]),
      .avail_i (in_avail_i),
      .sol_i   (in_sol_i),
      .eol_i   (in_eol_i),
      .z_o     (prod[g]),
      .avail_o (prod_avail[g]),
      .sol_o   (prod_sol[g]),
      .eol_o   (prod_eol[g])
    );

    gf64_mod_acc i_acc (
      .clk       (clk),
      .s_rst_n   (s_rst_n),
      .a_i       (prod[g]),
      .avail_i   (prod_avail[g]),
      .sol_i     (prod_sol[g]),
      .eol_i     (prod_eol[g]),
      .sum_o     (sums[g]),
      .sum_vld_o (sum_vld[g])
    );
  end

  // Lanes run in lockstep, lane 0 paces the drain
  ep_seq_fsm i_seq_fsm (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .in_avail_i  (in_avail_i),
    .in_eol_i    (in_eol_i),
    .sum_vld_i   (sum_vld[0]),
    .sums_i      (sums),
    .busy_o      (busy),
    .out_data_o  (out_data_o),
    .out_avail_o (out_avail_o),
    .out_sol_o   (out_sol_o),
    .out_eol_o   (out_eol_o)
  );

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
// ---------------------------------------------------------------------
// Free running testbench clock, 20 ns period
// Starts low at time 0
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  // Half period 10 ns
  always #10 clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== tb/gf64_ext_prod_assert.sv ====
// ---------------------------------------------------------------------
// Concurrent checks on the top level, attached by bind
// Output flags must stay quiet out of reset and travel with avail
// APB accesses must never stall
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module gf64_ext_prod_assert (
  input logic clk,
  input logic s_rst_n,
  input logic psel_i,
  input logic penable_i,
  input logic pready_i,
  input logic out_avail_i,
  input logic out_sol_i,
  input logic out_eol_i
);

  // Nothing leaves the sequencer right after reset
  assert property (@(posedge clk) !s_rst_n |=> !out_avail_i)
    else $error("out_avail_o high in the cycle after reset");

  // Line markers only on a valid word
  assert property (@(posedge clk) disable iff (!s_rst_n)
                   (out_sol_i || out_eol_i) |-> out_avail_i)
    else $error("out_sol_o or out_eol_o without out_avail_o");

  // Zero wait states in the access phase
  assert property (@(posedge clk) disable iff (!s_rst_n)
                   (psel_i && penable_i) |-> pready_i)
    else $error("pready_o low during an APB access phase");

endmodule

bind gf64_ext_prod_top gf64_ext_prod_assert i_assert (
  .clk         (clk),
  .s_rst_n     (s_rst_n),
  .psel_i      (psel_i),
  .penable_i   (penable_i),
  .pready_i    (pready_o),
  .out_avail_i (out_avail_o),
  .out_sol_i   (out_sol_o),
  .out_eol_i   (out_eol_o)
);

`default_nettype wire

// ==== tb/gf64_ext_prod_tb.sv ====
// ---------------------------------------------------------------------
// Testbench for the GF64 external-product MAC
// Inputs change 2 ns after the rising edge
// Outputs are sampled on the edge
// Keys are only reloaded once the output queue has drained
// Expected sums come from a 128-bit modular reference
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module gf64_ext_prod_tb;
  import gf64_ep_pkg::*;

  localparam int           N_RAND    = 50;
  localparam int           N_LINES   = N_RAND + 5;
  // Upper bound of 100 APB accesses at 3 cycles each
  localparam int           APB_CYC   = 100 * 3;
  localparam int           CYC_LIMIT = (N_LINES * ELT_NB + APB_CYC) * 2 + 200;
  localparam int           EOL_LAT   = 4;
  localparam logic [127:0] P_WIDE    = {64'd0, GF64_P};

  logic              clk;
  logic              s_rst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_AW-1:0] paddr;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;
  logic [COEF_W-1:0] in_data;
  logic              in_avail;
  logic              in_sol;
  logic              in_eol;
  logic [COEF_W-1:0] out_data;
  logic              out_avail;
  logic              out_sol;
  logic              out_eol;
  logic              error;

  // Model of the key bank indexed by row and column
  logic [COEF_W-1:0] key_tab [ELT_NB][GLWE_K_P1];
  logic [COEF_W-1:0] exp_q [$];
  bit                chk_q [$];
  int                eol_q [$];
  int                cyc;
  int                err_cnt;
  int                word_cnt;
  int                out_col;

  tb_clk_gen i_clk_gen (.clk_o(clk));

  gf64_ext_prod_top i_dut (
    .clk (clk), .s_rst_n (s_rst_n),
    .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
    .paddr_i (paddr), .pwdata_i (pwdata), .prdata_o (prdata),
    .pready_o (pready), .pslverr_o (pslverr),
    .in_data_i (in_data), .in_avail_i (in_avail),
    .in_sol_i (in_sol), .in_eol_i (in_eol),
    .out_data_o (out_data), .out_avail_o (out_avail),
    .out_sol_o (out_sol), .out_eol_o (out_eol),
    .error_o (error)
  );

  // ---------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------
  // Column sum of coef[r] * key[r][col] mod P
  function automatic logic [COEF_W-1:0] ref_ext_prod(input int col,
                                                     input logic [COEF_W-1:0] coefs [ELT_NB]);
    logic [127:0] acc;
    logic [127:0] prod;
    acc = '0;
    for (int r = 0; r < ELT_NB; r++) begin
      prod = {64'd0, coefs[r]} * {64'd0, key_tab[r][col]};
      acc  = (acc + (prod % P_WIDE)) % P_WIDE;
    end
    return acc[COEF_W-1:0];
  endfunction

  // Uniform canonical field element
  function automatic logic [COEF_W-1:0] rand_elt();
    logic [COEF_W-1:0] x;
    x = {$urandom(), $urandom()};
    return x % GF64_P;
  endfunction

  // ---------------------------------------------------------------------
  // Drivers
  // ---------------------------------------------------------------------
  // One APB transfer with its setup and access phase
  task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                          input logic [APB_DW-1:0] wdata,
                          output logic [APB_DW-1:0] rdata, output logic err);
    @(posedge clk);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(posedge clk);
    while (!pready) @(posedge clk);
    rdata = prdata;
    err   = pslverr;
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Copies key_tab into the DUT with the low half first
  task automatic load_keys();
    logic [APB_DW-1:0] rdata;
    logic              err;
    for (int r = 0; r < ELT_NB; r++) begin
      for (int c = 0; c < GLWE_K_P1; c++) begin
        apb_xfer(1'b1, APB_AW'(KEY_BASE + 8 * (r * GLWE_K_P1 + c)),
                 key_tab[r][c][31:0], rdata, err);
        apb_xfer(1'b1, APB_AW'(KEY_BASE + 8 * (r * GLWE_K_P1 + c) + 4),
                 key_tab[r][c][63:32], rdata, err);
      end
    end
  endtask

  task automatic drive_idle();
    @(posedge clk);
    #2;
    in_avail = 1'b0;
    in_sol   = 1'b0;
    in_eol   = 1'b0;
    in_data  = '0;
  endtask

  // Sends n_coef words with optional idle gaps
  // chk low skips the compare of that line
  task automatic send_line(input logic [COEF_W-1:0] coefs [ELT_NB], input int n_coef,
                           input bit gaps, input bit chk);
    int gap;
    for (int i = 0; i < n_coef; i++) begin
      gap = (gaps && i > 0 && ($urandom() % 4 == 0)) ? 1 + int'($urandom() % 2) : 0;
      repeat (gap) drive_idle();
      @(posedge clk);
      #2;
      in_avail = 1'b1;
      in_sol   = (i == 0);
      in_eol   = (i == n_coef - 1);
      in_data  = coefs[i];
    end
    for (int c = 0; c < GLWE_K_P1; c++) begin
      exp_q.push_back(chk ? ref_ext_prod(c, coefs) : '0);
      chk_q.push_back(chk);
    end
  endtask

  // Wait until every expected word came out
  task automatic wait_drain();
    while (exp_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  // ---------------------------------------------------------------------
  // Output compare
  // ---------------------------------------------------------------------
  always @(posedge clk) begin
    logic [COEF_W-1:0] exp_word;
    bit                chk;
    int                t_eol;
    if (out_avail) begin
      if (exp_q.size() == 0) begin
        $display("Output word at %0t arrived with nothing expected", $time);
        err_cnt++;
      end else begin
        exp_word = exp_q.pop_front();
        chk      = chk_q.pop_front();
        if (chk && out_data !== exp_word) begin
          $display("ERROR %0t: column %0d got %h expected %h", $time, out_col,
                   out_data, exp_word);
          err_cnt++;
        end
        if (chk && out_data >= GF64_P) begin
          $display("ERROR %0t: non canonical result %h", $time, out_data);
          err_cnt++;
        end
        if (chk) word_cnt++;
      end
      if (out_sol !== (out_col == 0) || out_eol !== (out_col == GLWE_K_P1 - 1)) begin
        $display("ERROR %0t: column %0d has sol=%b eol=%b", $time, out_col, out_sol,
                 out_eol);
        err_cnt++;
      end
      // Column 0 is due a fixed number of edges after eol
      if (out_sol && eol_q.size() != 0) begin
        t_eol = eol_q.pop_front();
        if (cyc - t_eol != EOL_LAT) begin
          $display("ERROR %0t: column 0 came %0d cycles after eol", $time, cyc - t_eol);
          err_cnt++;
        end
      end
      out_col = (out_col + 1) % GLWE_K_P1;
    end
    if (in_avail && in_eol) eol_q.push_back(cyc);
  end

  // Run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYC_LIMIT) begin
      $display("Run stopped after %0d cycles without finishing the tests", cyc);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ---------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------
  initial begin
    logic [COEF_W-1:0] line [ELT_NB];
    logic [COEF_W-1:0] corner [3];
    logic [COEF_W-1:0] key;
    logic [APB_DW-1:0] rdata;
    logic              err;
    s_rst_n  = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    in_data  = '0;
    in_avail = 1'b0;
    in_sol   = 1'b0;
    in_eol   = 1'b0;
    err_cnt  = 0;
    word_cnt = 0;
    out_col  = 0;
    void'($urandom(32'hc873c85b));
    repeat (10) @(posedge clk);
    #2;
    s_rst_n = 1'b1;

    // Key readback and unmapped access
    foreach (key_tab[r, c]) key_tab[r][c] = rand_elt();
    load_keys();
    for (int w = 0; w < KEY_WORDS; w++) begin
      key = key_tab[w / 4][(w / 2) % 2];
      apb_xfer(1'b0, APB_AW'(KEY_BASE + 4 * w), '0, rdata, err);
      if (err || rdata !== ((w % 2) ? key[63:32] : key[31:0])) begin
        $display("ERROR %0t: key word %0d read %h err=%b", $time, w, rdata, err);
        err_cnt++;
      end
    end
    apb_xfer(1'b0, 8'h80, '0, rdata, err);
    if (!err) begin
      $display("ERROR %0t: no pslverr on unmapped address 0x80", $time);
      err_cnt++;
    end

    // Small operands
    // Latency is checked by the compare process
    foreach (key_tab[r, c]) key_tab[r][c] = 64'(r * GLWE_K_P1 + c + 3);
    load_keys();
    foreach (line[i]) line[i] = 64'(i + 1);
    send_line(line, ELT_NB, 1'b0, 1'b1);
    drive_idle();
    wait_drain();

    // Reduction corners
    corner[0] = GF64_P - 64'd1;
    corner[1] = 64'h0000_0001_0000_0000;
    corner[2] = 64'hFFFF_FFFF_0000_0000;
    foreach (key_tab[r, c]) key_tab[r][c] = corner[(r + c) % 3];
    load_keys();
    foreach (line[i]) line[i] = corner[0];
    send_line(line, ELT_NB, 1'b0, 1'b1);
    foreach (line[i]) line[i] = corner[(i + 1) % 3];
    send_line(line, ELT_NB, 1'b0, 1'b1);
    drive_idle();
    wait_drain();

    // Back to back random lines
    foreach (key_tab[r, c]) key_tab[r][c] = rand_elt();
    load_keys();
    for (int n = 0; n < N_RAND; n++) begin
      foreach (line[i]) line[i] = rand_elt();
      send_line(line, ELT_NB, ($urandom() % 3 == 0), 1'b1);
    end
    drive_idle();
    wait_drain();

    // Short line sets the sticky error
    // Stream is idle by now so busy reads back 0
    foreach (line[i]) line[i] = rand_elt();
    send_line(line, ELT_NB - 1, 1'b0, 1'b0);
    drive_idle();
    wait_drain();
    apb_xfer(1'b0, STATUS_ADDR, '0, rdata, err);
    if (error !== 1'b1 || rdata[1:0] !== 2'b01) begin
      $display("ERROR %0t: short line gave error_o=%b status=%h", $time, error, rdata);
      err_cnt++;
    end
    apb_xfer(1'b1, STATUS_ADDR, 32'h1, rdata, err);
    apb_xfer(1'b0, STATUS_ADDR, '0, rdata, err);
    if (error !== 1'b0 || rdata[0] !== 1'b0) begin
      $display("ERROR %0t: clear left error_o=%b status=%h", $time, error, rdata);
      err_cnt++;
    end
    foreach (line[i]) line[i] = rand_elt();
    send_line(line, ELT_NB, 1'b0, 1'b1);
    drive_idle();
    wait_drain();

    $display("Checked %0d words, %0d errors", word_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
hw/gf64_ep_pkg.sv
hw/gf64_key_regs.sv
hw/gf64_mod_mult.sv
hw/gf64_mod_acc.sv
hw/ep_coef_counter.sv
hw/ep_seq_fsm.sv
hw/gf64_ext_prod_top.sv
tb/tb_clk_gen.sv
tb/gf64_ext_prod_assert.sv
tb/gf64_ext_prod_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the GF64 external-product testbench with Verilator
# Exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f list.f \
  --top-module gf64_ext_prod_tb -o sim_tb > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1

grep -qx "=== PASS ===" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed, see sim.log"; exit 1; }
